//--- src.f
common/emb_cfg_pkg.sv
common/emb_ctrl_pkg.sv
hw/emb_table_ram.sv
hw/emb_backward/emb_backward.sv
hw/emb_row_reader.sv
hw/emb_grad_ctrl.sv
hw/emb_grad_top.sv
verif/tb_emb_grad.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the gradient table testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_emb_grad \
  -f src.f \
  -o sim_emb_grad

out="$(./obj_dir/sim_emb_grad)"
echo "$out"

if grep -qx "RESULT: PASS" <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- verif/tb_emb_grad.sv
`timescale 1ns/1ns

module tb_emb_grad;

  import emb_cfg_pkg::*;
  import emb_ctrl_pkg::*;

  localparam int N_TOK     = N_TOK_DEF;
  localparam int CHAR_NUM  = CHAR_NUM_DEF;
  localparam int EMB_DIM   = EMB_DIM_DEF;
  localparam int DATA_N    = DATA_N_DEF;
  localparam int VAL_W     = VAL_W_DEF;
  localparam int ID_W      = id_w(CHAR_NUM);
  localparam int ROW_WORDS = row_words(EMB_DIM, DATA_N);
  localparam int WORD_W    = DATA_N * VAL_W;
  localparam int GRAD_W    = N_TOK * EMB_DIM * VAL_W;
  localparam int IDS_W     = N_TOK * ID_W;
  localparam int W         = N_TOK * ROW_WORDS;
  localparam int DEPTH     = CHAR_NUM * ROW_WORDS;
  localparam int PERIOD    = 100;
  // worst command latency plus the cycles around the strobe
  localparam int CMD_MAX   = ((DEPTH + 1 > W + 4) ? DEPTH + 1 : W + 4) + 2;
  localparam int N_CMDS    = 12;
  localparam int WATCHDOG  = (2 * N_CMDS * CMD_MAX + 3) * PERIOD;

  logic              clk;
  logic              rst_n;
  logic              cmd_valid;
  emb_op_e           cmd_op;
  logic [IDS_W-1:0]  tok_ids;
  logic [GRAD_W-1:0] grad;
  logic              busy;
  logic              done;
  logic              rd_valid;
  logic [WORD_W-1:0] rd_data;

  // reference table, lanes wrap like the hardware adders
  logic [VAL_W-1:0] ref_tab [CHAR_NUM][EMB_DIM];
  logic [15:0]      lfsr;
  int               ids_buf [N_TOK];
  int               errors;
  int               done_total;
  int               done_expected;

  emb_grad_top #(
    .N_TOK(N_TOK), .CHAR_NUM(CHAR_NUM), .EMB_DIM(EMB_DIM), .DATA_N(DATA_N), .VAL_W(VAL_W)
  ) UUT (
    .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .tok_ids(tok_ids), .grad(grad), .busy(busy), .done(done),
    .rd_valid(rd_valid), .rd_data(rd_data)
  );

  always #(PERIOD / 2) clk = ~clk;

  always @(negedge clk) begin
    if (rst_n && done) begin
      done_total++;
    end
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired after %0d ns, test sequence did not finish", WATCHDOG);
    $display("RESULT: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                            input logic [WORD_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus and reference model
  // --------------------------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per gradient bit
  task automatic random_grad(output logic [GRAD_W-1:0] g);
    for (int i = 0; i < GRAD_W; i++) begin
      g[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [IDS_W-1:0] pack_ids();
    logic [IDS_W-1:0] v;
    for (int t = 0; t < N_TOK; t++) begin
      v[t*ID_W +: ID_W] = ID_W'(ids_buf[t]);
    end
    return v;
  endfunction

  task automatic model_clear();
    for (int c = 0; c < CHAR_NUM; c++) begin
      for (int e = 0; e < EMB_DIM; e++) begin
        ref_tab[c][e] = '0;
      end
    end
  endtask

  task automatic model_backward(input logic [IDS_W-1:0] ids, input logic [GRAD_W-1:0] g);
    int id;
    for (int t = 0; t < N_TOK; t++) begin
      id = int'(ids[t*ID_W +: ID_W]);
      for (int e = 0; e < EMB_DIM; e++) begin
        ref_tab[id][e] = ref_tab[id][e] + g[(t*EMB_DIM + e)*VAL_W +: VAL_W];
      end
    end
  endtask

  // idx counts words in token-then-word order
  function automatic logic [WORD_W-1:0] model_word(input logic [IDS_W-1:0] ids, input int idx);
    logic [WORD_W-1:0] v;
    int id;
    int w;
    id = int'(ids[(idx / ROW_WORDS)*ID_W +: ID_W]);
    w  = idx % ROW_WORDS;
    for (int l = 0; l < DATA_N; l++) begin
      v[l*VAL_W +: VAL_W] = ref_tab[id][w*DATA_N + l];
    end
    return v;
  endfunction

  // strobe one command, optionally a second strobe at cycle stray_at
  // that the DUT must drop, then follow the run until done
  task automatic run_cmd(input emb_op_e op, input logic [IDS_W-1:0] ids,
                         input logic [GRAD_W-1:0] g, input int stray_at,
                         input emb_op_e stray_op);
    int cyc;
    int exp_done;
    int done_cyc;
    int rd_cnt;
    int first_rd;
    exp_done = (op == op_clear) ? DEPTH + 1 : W + 4;
    done_cyc = -1;
    rd_cnt   = 0;
    first_rd = -1;
    cyc      = 0;
    @(posedge clk);
    #10;
    cmd_valid = 1'b1;
    cmd_op    = op;
    tok_ids   = ids;
    grad      = g;
    @(posedge clk);
    #10;
    while (done_cyc < 0 && cyc < 2 * CMD_MAX) begin
      cmd_valid = (cyc == stray_at);
      cmd_op    = (cyc == stray_at) ? stray_op : op_nop;
      if (cyc == stray_at) begin
        tok_ids = ~ids;
        grad    = ~g;
      end
      @(negedge clk);
      cyc++;
      if (cyc == 1) begin
        check_flag("busy", 1'b1, busy);
      end
      if (rd_valid) begin
        if (first_rd < 0) begin
          first_rd = cyc;
        end
        if (rd_cnt < W) begin
          check_word("rd_data", model_word(ids, rd_cnt), rd_data);
        end
        rd_cnt++;
      end
      if (done) begin
        done_cyc = cyc;
      end
      @(posedge clk);
      #10;
    end
    cmd_valid = 1'b0;
    cmd_op    = op_nop;
    done_expected++;
    if (done_cyc < 0) begin
      errors++;
      $display("no done strobe within %0d cycles of the command", 2 * CMD_MAX);
    end else begin
      check_count("done_cycle", exp_done, done_cyc);
    end
    check_count("rd_valid_count", (op == op_read) ? W : 0, rd_cnt);
    if (op == op_read) begin
      check_count("first_rd_valid_cycle", 4, first_rd);
    end
    if (op == op_backward) begin
      model_backward(ids, g);
    end
    if (op == op_clear) begin
      model_clear();
    end
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic clear_then_read();
    for (int t = 0; t < N_TOK; t++) begin
      ids_buf[t] = (t * 4 + 3) % CHAR_NUM;
    end
    run_cmd(op_clear, '0, '0, -1, op_nop);
    run_cmd(op_read, pack_ids(), '0, -1, op_nop);
  endtask

  task automatic distinct_rows();
    logic [GRAD_W-1:0] g;
    for (int t = 0; t < N_TOK; t++) begin
      ids_buf[t] = (t * 5 + 1) % CHAR_NUM;
    end
    random_grad(g);
    run_cmd(op_backward, pack_ids(), g, -1, op_nop);
    run_cmd(op_read, pack_ids(), '0, -1, op_nop);
  endtask

  // back-to-back tokens on one row go through the forwarding path
  task automatic repeated_id();
    logic [GRAD_W-1:0] g;
    for (int t = 0; t < N_TOK; t++) begin
      ids_buf[t] = (t < N_TOK - 1) ? 11 : 2;
    end
    random_grad(g);
    run_cmd(op_backward, pack_ids(), g, -1, op_nop);
    run_cmd(op_read, pack_ids(), '0, -1, op_nop);
  endtask

  task automatic two_batches();
    logic [GRAD_W-1:0] g;
    for (int t = 0; t < N_TOK; t++) begin
      ids_buf[t] = (t * 3 + 2) % CHAR_NUM;
    end
    random_grad(g);
    run_cmd(op_backward, pack_ids(), g, -1, op_nop);
    for (int t = 0; t < N_TOK; t++) begin
      ids_buf[t] = (t * 3 + 5) % CHAR_NUM;
    end
    random_grad(g);
    run_cmd(op_backward, pack_ids(), g, -1, op_nop);
    run_cmd(op_read, pack_ids(), '0, -1, op_nop);
  endtask

  // strays mid-run and on the done cycle itself
  task automatic busy_drop();
    logic [GRAD_W-1:0] g;
    for (int t = 0; t < N_TOK; t++) begin
      ids_buf[t] = (t + 7) % CHAR_NUM;
    end
    random_grad(g);
    run_cmd(op_backward, pack_ids(), g, 3, op_clear);
    random_grad(g);
    run_cmd(op_backward, pack_ids(), g, W + 3, op_read);
    run_cmd(op_read, pack_ids(), '0, 5, op_backward);
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    cmd_valid     = 1'b0;
    cmd_op        = op_nop;
    tok_ids       = '0;
    grad          = '0;
    lfsr          = 16'd71;
    errors        = 0;
    done_total    = 0;
    done_expected = 0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    check_flag("rd_valid", 1'b0, rd_valid);
    clear_then_read();
    distinct_rows();
    repeated_id();
    two_batches();
    busy_drop();
    check_count("done_count", done_expected, done_total);
    $display("finished: %0d errors, %0d done strobes, %0d commands", errors, done_total,
             done_expected);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- hw/emb_grad_top.sv
`timescale 1ns/1ns

module emb_grad_top #(
  parameter int N_TOK    = emb_cfg_pkg::N_TOK_DEF,
  parameter int CHAR_NUM = emb_cfg_pkg::CHAR_NUM_DEF,
  parameter int EMB_DIM  = emb_cfg_pkg::EMB_DIM_DEF,
  parameter int DATA_N   = emb_cfg_pkg::DATA_N_DEF,
  parameter int VAL_W    = emb_cfg_pkg::VAL_W_DEF,
  localparam int ID_W    = emb_cfg_pkg::id_w(CHAR_NUM),
  localparam int ADDR_W  = emb_cfg_pkg::addr_w(CHAR_NUM, EMB_DIM, DATA_N),
  localparam int WORD_W  = DATA_N * VAL_W,
  localparam int GRAD_W  = N_TOK * EMB_DIM * VAL_W
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  emb_ctrl_pkg::emb_op_e cmd_op,
  input  logic [N_TOK*ID_W-1:0] tok_ids,
  input  logic [GRAD_W-1:0]     grad,
  output logic                  busy,
  output logic                  done,
  output logic                  rd_valid,
  output logic [WORD_W-1:0]     rd_data
);

  // latched command
  logic [N_TOK*ID_W-1:0] tok_ids_q;
  logic [GRAD_W-1:0]     grad_q;

  // engine handshakes
  logic bwd_start;
  logic bwd_finish;
  logic rdr_start;
  logic rdr_finish;

  // engine side of the RAM ports
  logic [ADDR_W-1:0] bwd_raddr;
  logic [ADDR_W-1:0] rdr_raddr;
  logic              bwd_we;
  logic [ADDR_W-1:0] bwd_waddr;
  logic [WORD_W-1:0] bwd_wdata;

  // RAM side
  logic [ADDR_W-1:0] ram_raddr;
  logic [WORD_W-1:0] ram_rdata;
  logic              ram_we;
  logic [ADDR_W-1:0] ram_waddr;
  logic [WORD_W-1:0] ram_wdata;

  emb_grad_ctrl #(
    .N_TOK(N_TOK), .CHAR_NUM(CHAR_NUM), .EMB_DIM(EMB_DIM), .DATA_N(DATA_N), .VAL_W(VAL_W)
  ) u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_op(cmd_op), .tok_ids_in(tok_ids), .grad_in(grad),
    .tok_ids(tok_ids_q), .grad(grad_q),
    .bwd_start(bwd_start), .rdr_start(rdr_start),
    .bwd_finish(bwd_finish), .rdr_finish(rdr_finish),
    .bwd_raddr(bwd_raddr), .rdr_raddr(rdr_raddr),
    .bwd_we(bwd_we), .bwd_waddr(bwd_waddr), .bwd_wdata(bwd_wdata),
    .ram_raddr(ram_raddr), .ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
    .busy(busy), .done(done)
  );

  emb_backward #(
    .N_TOK(N_TOK), .CHAR_NUM(CHAR_NUM), .EMB_DIM(EMB_DIM), .DATA_N(DATA_N), .VAL_W(VAL_W)
  ) u_backward (
    .clk(clk), .rst_n(rst_n), .start(bwd_start),
    .tok_ids(tok_ids_q), .grad(grad_q),
    .raddr(bwd_raddr), .rdata(ram_rdata),
    .we(bwd_we), .waddr(bwd_waddr), .wdata(bwd_wdata),
    .finish(bwd_finish)
  );

  emb_row_reader #(
    .N_TOK(N_TOK), .CHAR_NUM(CHAR_NUM), .EMB_DIM(EMB_DIM), .DATA_N(DATA_N), .VAL_W(VAL_W)
  ) u_reader (
    .clk(clk), .rst_n(rst_n), .start(rdr_start), .tok_ids(tok_ids_q),
    .raddr(rdr_raddr), .rdata(ram_rdata),
    .rd_valid(rd_valid), .rd_data(rd_data), .finish(rdr_finish)
  );

  emb_table_ram #(
    .CHAR_NUM(CHAR_NUM), .EMB_DIM(EMB_DIM), .DATA_N(DATA_N), .VAL_W(VAL_W)
  ) u_ram (
    .clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
    .raddr(ram_raddr), .rdata(ram_rdata)
  );

endmodule

//--- hw/emb_grad_ctrl.sv
`timescale 1ns/1ns

module emb_grad_ctrl #(
  parameter int N_TOK    = emb_cfg_pkg::N_TOK_DEF,
  parameter int CHAR_NUM = emb_cfg_pkg::CHAR_NUM_DEF,
  parameter int EMB_DIM  = emb_cfg_pkg::EMB_DIM_DEF,
  parameter int DATA_N   = emb_cfg_pkg::DATA_N_DEF,
  parameter int VAL_W    = emb_cfg_pkg::VAL_W_DEF,
  localparam int ID_W    = emb_cfg_pkg::id_w(CHAR_NUM),
  localparam int ADDR_W  = emb_cfg_pkg::addr_w(CHAR_NUM, EMB_DIM, DATA_N),
  localparam int WORD_W  = DATA_N * VAL_W,
  localparam int GRAD_W  = N_TOK * EMB_DIM * VAL_W
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  emb_ctrl_pkg::emb_op_e cmd_op,
  input  logic [N_TOK*ID_W-1:0] tok_ids_in,
  input  logic [GRAD_W-1:0]     grad_in,
  output logic [N_TOK*ID_W-1:0] tok_ids,
  output logic [GRAD_W-1:0]     grad,
  output logic                  bwd_start,
  output logic                  rdr_start,
  input  logic                  bwd_finish,
  input  logic                  rdr_finish,
  input  logic [ADDR_W-1:0]     bwd_raddr,
  input  logic [ADDR_W-1:0]     rdr_raddr,
  input  logic                  bwd_we,
  input  logic [ADDR_W-1:0]     bwd_waddr,
  input  logic [WORD_W-1:0]     bwd_wdata,
  output logic [ADDR_W-1:0]     ram_raddr,
  output logic                  ram_we,
  output logic [ADDR_W-1:0]     ram_waddr,
  output logic [WORD_W-1:0]     ram_wdata,
  output logic                  busy,
  output logic                  done
);

  import emb_cfg_pkg::*;
  import emb_ctrl_pkg::*;

  localparam int DEPTH = CHAR_NUM * row_words(EMB_DIM, DATA_N);

  ctrl_state_e       state;
  logic [ADDR_W-1:0] clr_cnt;
  logic              accept;

  // the done cycle still counts as busy
  assign busy   = (state != st_idle) || done;
  assign accept = cmd_valid && !busy && (cmd_op != op_nop);

  // -------------------------------------------------------------------------
  // command FSM and clear sweep
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      clr_cnt   <= '0;
      done      <= 1'b0;
      bwd_start <= 1'b0;
      rdr_start <= 1'b0;
    end else begin
      done      <= 1'b0;
      bwd_start <= 1'b0;
      rdr_start <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            case (cmd_op)
              op_clear: begin
                state   <= st_clear;
                clr_cnt <= '0;
              end
              op_backward: begin
                state     <= st_backward;
                bwd_start <= 1'b1;
              end
              op_read: begin
                state     <= st_read;
                rdr_start <= 1'b1;
              end
              default: ;
            endcase
          end
        end
        st_clear: begin
          if (clr_cnt == ADDR_W'(DEPTH - 1)) begin
            state <= st_idle;
            done  <= 1'b1;
          end else begin
            clr_cnt <= clr_cnt + 1'b1;
          end
        end
        st_backward: begin
          if (bwd_finish) begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        st_read: begin
          if (rdr_finish) begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // command payload, held for the whole run
  always_ff @(posedge clk) begin
    if (accept) begin
      tok_ids <= tok_ids_in;
      grad    <= grad_in;
    end
  end

  // RAM ports follow the running engine
  assign ram_we    = (state == st_clear) || (state == st_backward && bwd_we);
  assign ram_waddr = (state == st_clear) ? clr_cnt : bwd_waddr;
  assign ram_wdata = (state == st_clear) ? '0 : bwd_wdata;
  assign ram_raddr = (state == st_read) ? rdr_raddr : bwd_raddr;

  // no engine is launched by a command that shows up together with done
  a_done_no_accept: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> (state == st_idle && !bwd_start && !rdr_start)
  );

endmodule

//--- hw/emb_row_reader.sv
`timescale 1ns/1ns

module emb_row_reader #(
  parameter int N_TOK    = emb_cfg_pkg::N_TOK_DEF,
  parameter int CHAR_NUM = emb_cfg_pkg::CHAR_NUM_DEF,
  parameter int EMB_DIM  = emb_cfg_pkg::EMB_DIM_DEF,
  parameter int DATA_N   = emb_cfg_pkg::DATA_N_DEF,
  parameter int VAL_W    = emb_cfg_pkg::VAL_W_DEF,
  localparam int ID_W    = emb_cfg_pkg::id_w(CHAR_NUM),
  localparam int ADDR_W  = emb_cfg_pkg::addr_w(CHAR_NUM, EMB_DIM, DATA_N),
  localparam int WORD_W  = DATA_N * VAL_W
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [N_TOK*ID_W-1:0] tok_ids,
  output logic [ADDR_W-1:0]     raddr,
  input  logic [WORD_W-1:0]     rdata,
  output logic                  rd_valid,
  output logic [WORD_W-1:0]     rd_data,
  output logic                  finish
);

  import emb_cfg_pkg::*;

  localparam int ROW_WORDS = row_words(EMB_DIM, DATA_N);
  localparam int TOTAL     = N_TOK * ROW_WORDS;
  localparam int TC_W      = cnt_w(N_TOK);
  localparam int WC_W      = cnt_w(ROW_WORDS);
  localparam int GC_W      = cnt_w(TOTAL);

  logic            active;
  logic [TC_W-1:0] tok_cnt;
  logic [WC_W-1:0] word_cnt;
  logic [GC_W-1:0] g_cnt;
  logic [ID_W-1:0] cur_id;
  logic            last0;
  logic            v1;
  logic            last1;

  assign cur_id = tok_ids[tok_cnt*ID_W +: ID_W];
  assign raddr  = ADDR_W'(cur_id) * ADDR_W'(ROW_WORDS) + ADDR_W'(word_cnt);
  assign last0  = active && (g_cnt == GC_W'(TOTAL - 1));

  // token-then-word address order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      tok_cnt  <= '0;
      word_cnt <= '0;
      g_cnt    <= '0;
    end else if (start) begin
      active   <= 1'b1;
      tok_cnt  <= '0;
      word_cnt <= '0;
      g_cnt    <= '0;
    end else if (active) begin
      if (last0) begin
        active <= 1'b0;
      end else begin
        g_cnt <= g_cnt + 1'b1;
        if (word_cnt == WC_W'(ROW_WORDS - 1)) begin
          word_cnt <= '0;
          tok_cnt  <= tok_cnt + 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // valid follows the RAM latency plus the output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1       <= 1'b0;
      last1    <= 1'b0;
      rd_valid <= 1'b0;
      finish   <= 1'b0;
    end else begin
      v1       <= active;
      last1    <= last0;
      rd_valid <= v1;
      finish   <= last1;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= rdata;
  end

endmodule

//--- hw/emb_backward/emb_backward.sv
`timescale 1ns/1ns

module emb_backward #(
  parameter int N_TOK    = emb_cfg_pkg::N_TOK_DEF,
  parameter int CHAR_NUM = emb_cfg_pkg::CHAR_NUM_DEF,
  parameter int EMB_DIM  = emb_cfg_pkg::EMB_DIM_DEF,
  parameter int DATA_N   = emb_cfg_pkg::DATA_N_DEF,
  parameter int VAL_W    = emb_cfg_pkg::VAL_W_DEF,
  localparam int ID_W    = emb_cfg_pkg::id_w(CHAR_NUM),
  localparam int ADDR_W  = emb_cfg_pkg::addr_w(CHAR_NUM, EMB_DIM, DATA_N),
  localparam int WORD_W  = DATA_N * VAL_W
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  logic [N_TOK*ID_W-1:0]          tok_ids,
  input  logic [N_TOK*EMB_DIM*VAL_W-1:0] grad,
  output logic [ADDR_W-1:0]              raddr,
  input  logic [WORD_W-1:0]              rdata,
  output logic                           we,
  output logic [ADDR_W-1:0]              waddr,
  output logic [WORD_W-1:0]              wdata,
  output logic                           finish
);

  import emb_cfg_pkg::*;

  localparam int ROW_WORDS = row_words(EMB_DIM, DATA_N);
  localparam int TOTAL     = N_TOK * ROW_WORDS;
  localparam int TC_W      = cnt_w(N_TOK);
  localparam int WC_W      = cnt_w(ROW_WORDS);
  localparam int GC_W      = cnt_w(TOTAL);

  // read sequencer
  logic            active;
  logic [TC_W-1:0] tok_cnt;
  logic [WC_W-1:0] word_cnt;
  logic [GC_W-1:0] g_cnt;
  logic [ID_W-1:0] cur_id;
  logic            last0;

  // stage 1, read data arrives
  logic              v1;
  logic              last1;
  logic [ADDR_W-1:0] a1;
  logic [GC_W-1:0]   g1;

  // previous write, still pending in the RAM read path
  logic              we_d;
  logic [ADDR_W-1:0] waddr_d;
  logic [WORD_W-1:0] wdata_d;

  logic [WORD_W-1:0] src;
  logic [WORD_W-1:0] gslice;
  logic [WORD_W-1:0] sum;

  assign cur_id = tok_ids[tok_cnt*ID_W +: ID_W];
  assign raddr  = ADDR_W'(cur_id) * ADDR_W'(ROW_WORDS) + ADDR_W'(word_cnt);
  assign last0  = active && (g_cnt == GC_W'(TOTAL - 1));

  // -------------------------------------------------------------------------
  // address counters, word within row and token within batch
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      tok_cnt  <= '0;
      word_cnt <= '0;
      g_cnt    <= '0;
    end else if (start) begin
      active   <= 1'b1;
      tok_cnt  <= '0;
      word_cnt <= '0;
      g_cnt    <= '0;
    end else if (active) begin
      if (last0) begin
        active <= 1'b0;
      end else begin
        g_cnt <= g_cnt + 1'b1;
        if (word_cnt == WC_W'(ROW_WORDS - 1)) begin
          word_cnt <= '0;
          tok_cnt  <= tok_cnt + 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // forwarding and lane adders
  // -------------------------------------------------------------------------
  // newest pending write wins over the older one
  always_comb begin
    if (we && waddr == a1) begin
      src = wdata;
    end else if (we_d && waddr_d == a1) begin
      src = wdata_d;
    end else begin
      src = rdata;
    end
    gslice = grad[g1*WORD_W +: WORD_W];
    for (int l = 0; l < DATA_N; l++) begin
      sum[l*VAL_W +: VAL_W] = src[l*VAL_W +: VAL_W] + gslice[l*VAL_W +: VAL_W];
    end
  end

  // -------------------------------------------------------------------------
  // pipeline control
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1     <= 1'b0;
      last1  <= 1'b0;
      we     <= 1'b0;
      we_d   <= 1'b0;
      finish <= 1'b0;
    end else begin
      v1     <= active;
      last1  <= last0;
      we     <= v1;
      we_d   <= we;
      finish <= v1 && last1;
    end
  end

  // address, index and data travel without reset
  always_ff @(posedge clk) begin
    a1      <= raddr;
    g1      <= g_cnt;
    waddr   <= a1;
    wdata   <= sum;
    waddr_d <= waddr;
    wdata_d <= wdata;
  end

  // controller only starts this engine once the previous run has drained
  a_start_idle: assert property (
    @(posedge clk) disable iff (!rst_n) start |-> !(active || v1 || we)
  );

  a_no_we_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !we ##1 !we
  );

endmodule

//--- hw/emb_table_ram.sv
`timescale 1ns/1ns

module emb_table_ram #(
  parameter int CHAR_NUM = emb_cfg_pkg::CHAR_NUM_DEF,
  parameter int EMB_DIM  = emb_cfg_pkg::EMB_DIM_DEF,
  parameter int DATA_N   = emb_cfg_pkg::DATA_N_DEF,
  parameter int VAL_W    = emb_cfg_pkg::VAL_W_DEF,
  localparam int ADDR_W  = emb_cfg_pkg::addr_w(CHAR_NUM, EMB_DIM, DATA_N),
  localparam int WORD_W  = DATA_N * VAL_W
) (
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] waddr,
  input  logic [WORD_W-1:0] wdata,
  input  logic [ADDR_W-1:0] raddr,
  output logic [WORD_W-1:0] rdata
);

  import emb_cfg_pkg::*;

  localparam int DEPTH = CHAR_NUM * row_words(EMB_DIM, DATA_N);

  // one gradient row is row_words consecutive entries
  logic [WORD_W-1:0] mem [DEPTH];

  // read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

  // writes from the clear sweep and the accumulator stay inside the table
  a_waddr_range: assert property (
    @(posedge clk) we |-> (int'(waddr) < DEPTH)
  );

endmodule

//--- common/emb_ctrl_pkg.sv
package emb_ctrl_pkg;

  // command opcodes on the top port
  typedef enum logic [1:0] {
    op_nop      = 2'd0,
    op_clear    = 2'd1,
    op_backward = 2'd2,
    op_read     = 2'd3
  } emb_op_e;

  // controller states, one per engine plus idle
  typedef enum logic [1:0] {
    st_idle     = 2'd0,
    st_clear    = 2'd1,
    st_backward = 2'd2,
    st_read     = 2'd3
  } ctrl_state_e;

endpackage

//--- common/emb_cfg_pkg.sv
package emb_cfg_pkg;

  // default table dimensions
  localparam int N_TOK_DEF    = 4;
  localparam int CHAR_NUM_DEF = 16;
  localparam int EMB_DIM_DEF  = 8;
  localparam int DATA_N_DEF   = 4;
  localparam int VAL_W_DEF    = 16;

  // counter width for values 0..n-1, at least one bit
  function automatic int cnt_w(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  function automatic int id_w(input int char_num);
    return cnt_w(char_num);
  endfunction

  // memory words per table row
  function automatic int row_words(input int emb_dim, input int data_n);
    return emb_dim / data_n;
  endfunction

  function automatic int addr_w(input int char_num, input int emb_dim, input int data_n);
    return cnt_w(char_num * row_words(emb_dim, data_n));
  endfunction

endpackage
